//--- common/wb_pkg.sv
package wb_pkg;

    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 8;

    // Byte offset inside one 32-bit memory word
    localparam int WB_OFF_W = 2;
    localparam int WB_WORD_ADDR_W = WB_ADDR_W - WB_OFF_W;

    // Byte address as seen on the bus
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    // One data byte
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // Lane number of a byte address
    function automatic logic [WB_OFF_W-1:0] wb_byte_off(input wb_addr_t adr);
        return adr[WB_OFF_W-1:0];
    endfunction

endpackage

//--- common/mcb_pkg.sv
package mcb_pkg;

    localparam int MCB_INSTR_W = 3;
    localparam int MCB_LANES = 4;
    localparam int MCB_LANE_W = 8;
    localparam int MCB_LANE_SEL_W = 2;
    localparam int MCB_WORD_W = MCB_LANES * MCB_LANE_W;

    // Port command codes, only single-word transfers are used
    typedef enum logic [MCB_INSTR_W-1:0] {
        MCB_WRITE = 3'b000,
        MCB_READ  = 3'b001
    } mcb_instr_e;

    typedef logic [MCB_LANE_W-1:0] mcb_lane_t;

    // One memory word, seen whole or as byte lanes
    typedef union packed {
        logic [MCB_WORD_W-1:0]          word;
        mcb_lane_t [MCB_LANES-1:0]      lane;
    } mcb_word_u;

    // Set bit keeps that lane unchanged
    typedef logic [MCB_LANES-1:0] mcb_mask_t;

    // Mask that lets only the selected lane through
    function automatic mcb_mask_t mcb_lane_mask(input logic [MCB_LANE_SEL_W-1:0] sel);
        return ~(mcb_mask_t'(1) << sel);
    endfunction

endpackage

//--- hw/wb_mcb_8.sv
`timescale 1ns/1ps

module wb_mcb_8 (
    input  logic                               clk,
    input  logic                               rst,
    input  wb_pkg::wb_addr_t                   wb_adr_i,
    input  wb_pkg::wb_data_t                   wb_dat_i,
    output wb_pkg::wb_data_t                   wb_dat_o,
    input  logic                               wb_we_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_cyc_i,
    output logic                               wb_ack_o,
    output logic                               cmd_push_o,
    output mcb_pkg::mcb_instr_e                cmd_instr_o,
    output logic [wb_pkg::WB_WORD_ADDR_W-1:0]  cmd_word_addr_o,
    input  logic                               cmd_full_i,
    output logic                               wr_push_o,
    output mcb_pkg::mcb_word_u                 wr_data_o,
    output mcb_pkg::mcb_mask_t                 wr_mask_o,
    input  logic                               wr_full_i,
    output logic                               rd_pop_o,
    input  mcb_pkg::mcb_word_u                 rd_data_i,
    input  logic                               rd_empty_i
);
    import wb_pkg::*;
    import mcb_pkg::*;

    logic                rd_wait_q;
    logic [WB_OFF_W-1:0] rd_off_q;
    logic                wb_ack_q;
    logic                cmd_push_q;
    logic                wr_push_q;
    wb_data_t            wb_dat_q;
    logic                req;
    logic                room;
    logic                accept;
    logic                rd_done;

    // New requests only in idle and never while ack is out
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_q & ~rd_wait_q;
    // Writes need room in both queues, reads only in the command queue
    assign room = ~cmd_full_i & (~wb_we_i | ~wr_full_i);
    assign accept = req & room;
    assign rd_done = rd_wait_q & ~rd_empty_i;

    // Master holds address and data until ack, so these stay valid for the push
    assign cmd_instr_o = wb_we_i ? MCB_WRITE : MCB_READ;
    assign cmd_word_addr_o = wb_adr_i[WB_ADDR_W-1:WB_OFF_W];
    assign wr_mask_o = mcb_lane_mask(wb_byte_off(wb_adr_i));

    always_comb begin
        for (int i = 0; i < MCB_LANES; i++) begin
            wr_data_o.lane[i] = wb_dat_i;
        end
    end

    assign cmd_push_o = cmd_push_q;
    assign wr_push_o = wr_push_q;
    assign rd_pop_o = rd_done;
    assign wb_ack_o = wb_ack_q;
    assign wb_dat_o = wb_dat_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait_q  <= 1'b0;
            wb_ack_q   <= 1'b0;
            cmd_push_q <= 1'b0;
            wr_push_q  <= 1'b0;
        end else begin
            wb_ack_q   <= 1'b0;
            cmd_push_q <= 1'b0;
            wr_push_q  <= 1'b0;
            if (rd_done) begin
                rd_wait_q <= 1'b0;
                wb_ack_q  <= 1'b1;
            end else if (accept) begin
                cmd_push_q <= 1'b1;
                if (wb_we_i) begin
                    // Posted write, ack goes out with the push
                    wr_push_q <= 1'b1;
                    wb_ack_q  <= 1'b1;
                end else begin
                    rd_wait_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_off_q <= wb_byte_off(wb_adr_i);
        end
        if (rd_done) begin
            wb_dat_q <= rd_data_i.lane[rd_off_q];
        end
    end

endmodule

//--- mcb_model/mcb_fifo.sv
`timescale 1ns/1ps

module mcb_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    output logic             full_o,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop = pop_i & ~empty_o;

    // Front entry is always on the output
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- mcb_model/mcb_mem_engine.sv
`timescale 1ns/1ps

module mcb_mem_engine #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_empty_i,
    input  mcb_pkg::mcb_instr_e   cmd_instr_i,
    input  logic [MEM_ADDR_W-1:0] cmd_word_addr_i,
    output logic                  cmd_pop_o,
    input  logic                  wr_empty_i,
    input  mcb_pkg::mcb_word_u    wr_data_i,
    input  mcb_pkg::mcb_mask_t    wr_mask_i,
    output logic                  wr_pop_o,
    input  logic                  rd_full_i,
    output logic                  rd_push_o,
    output mcb_pkg::mcb_word_u    rd_data_o
);
    import mcb_pkg::*;

    localparam int MEM_WORDS = 2 ** MEM_ADDR_W;

    logic [MCB_WORD_W-1:0] mem [MEM_WORDS];
    mcb_word_u             cur_word;
    mcb_word_u             merged;
    mcb_word_u             rd_word_q;
    logic                  rd_pend_q;
    logic                  cmd_valid;
    logic                  wr_go;
    logic                  rd_go;

    // One command at a time, nothing new while a read word waits to go out
    assign cmd_valid = ~cmd_empty_i & ~rd_pend_q;

    // Write needs its data word queued as well
    assign wr_go = cmd_valid & (cmd_instr_i == MCB_WRITE) & ~wr_empty_i;

    // Read holds off until the return queue has room
    assign rd_go = cmd_valid & (cmd_instr_i == MCB_READ) & ~rd_full_i;

    assign cmd_pop_o = wr_go | rd_go;
    assign wr_pop_o = wr_go;
    assign rd_push_o = rd_pend_q;
    assign rd_data_o = rd_word_q;

    assign cur_word = mem[cmd_word_addr_i];

    // Merge new lanes into the stored word
    always_comb begin
        merged = cur_word;
        for (int i = 0; i < MCB_LANES; i++) begin
            if (!wr_mask_i[i]) begin
                merged.lane[i] = wr_data_i.lane[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[cmd_word_addr_i] <= merged.word;
        end
        if (rd_go) begin
            rd_word_q <= cur_word;
        end
    end

    // Captured word is pushed on the cycle after the command pop
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_go;
        end
    end

endmodule

//--- hw/wb_mcb_top.sv
`timescale 1ns/1ps

module wb_mcb_top #(
    parameter int MEM_ADDR_W = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  wb_pkg::wb_addr_t wb_adr_i,
    input  wb_pkg::wb_data_t wb_dat_i,
    output wb_pkg::wb_data_t wb_dat_o,
    input  logic             wb_we_i,
    input  logic             wb_stb_i,
    input  logic             wb_cyc_i,
    output logic             wb_ack_o
);
    import mcb_pkg::*;

    localparam int CMD_W = MCB_INSTR_W + MEM_ADDR_W;
    localparam int WR_W = MCB_WORD_W + MCB_LANES;

    // Bridge side
    logic                              br_cmd_push;
    mcb_instr_e                        br_cmd_instr;
    logic [wb_pkg::WB_WORD_ADDR_W-1:0] br_word_addr;
    logic                              cmd_full;
    logic                              br_wr_push;
    mcb_word_u                         br_wr_data;
    mcb_mask_t                         br_wr_mask;
    logic                              wr_full;
    logic                              br_rd_pop;
    mcb_word_u                         rd_q_data;
    logic                              rd_empty;

    // Engine side
    logic [CMD_W-1:0]                  cmd_q_data;
    logic                              cmd_empty;
    logic                              eng_cmd_pop;
    mcb_instr_e                        eng_cmd_instr;
    logic [WR_W-1:0]                   wr_q_data;
    logic                              wr_empty;
    logic                              eng_wr_pop;
    mcb_word_u                         eng_wr_data;
    mcb_mask_t                         eng_wr_mask;
    logic                              rd_full;
    logic                              eng_rd_push;
    mcb_word_u                         eng_rd_data;

    assign eng_cmd_instr = mcb_instr_e'(cmd_q_data[MEM_ADDR_W +: MCB_INSTR_W]);
    assign eng_wr_data = wr_q_data[MCB_WORD_W-1:0];
    assign eng_wr_mask = wr_q_data[MCB_WORD_W +: MCB_LANES];

    wb_mcb_8 u_bridge (
        .clk             (clk),
        .rst             (rst),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_we_i         (wb_we_i),
        .wb_stb_i        (wb_stb_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_ack_o        (wb_ack_o),
        .cmd_push_o      (br_cmd_push),
        .cmd_instr_o     (br_cmd_instr),
        .cmd_word_addr_o (br_word_addr),
        .cmd_full_i      (cmd_full),
        .wr_push_o       (br_wr_push),
        .wr_data_o       (br_wr_data),
        .wr_mask_o       (br_wr_mask),
        .wr_full_i       (wr_full),
        .rd_pop_o        (br_rd_pop),
        .rd_data_i       (rd_q_data),
        .rd_empty_i      (rd_empty)
    );

    // Word address is cut down to the array size
    mcb_fifo #(.WIDTH(CMD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_cmd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (br_cmd_push),
        .data_i  ({br_cmd_instr, br_word_addr[MEM_ADDR_W-1:0]}),
        .full_o  (cmd_full),
        .pop_i   (eng_cmd_pop),
        .data_o  (cmd_q_data),
        .empty_o (cmd_empty)
    );

    mcb_fifo #(.WIDTH(WR_W), .FIFO_DEPTH(FIFO_DEPTH)) u_wr_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (br_wr_push),
        .data_i  ({br_wr_mask, br_wr_data}),
        .full_o  (wr_full),
        .pop_i   (eng_wr_pop),
        .data_o  (wr_q_data),
        .empty_o (wr_empty)
    );

    mcb_fifo #(.WIDTH(MCB_WORD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_rd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (eng_rd_push),
        .data_i  (eng_rd_data),
        .full_o  (rd_full),
        .pop_i   (br_rd_pop),
        .data_o  (rd_q_data),
        .empty_o (rd_empty)
    );

    mcb_mem_engine #(.MEM_ADDR_W(MEM_ADDR_W)) u_engine (
        .clk             (clk),
        .rst             (rst),
        .cmd_empty_i     (cmd_empty),
        .cmd_instr_i     (eng_cmd_instr),
        .cmd_word_addr_i (cmd_q_data[MEM_ADDR_W-1:0]),
        .cmd_pop_o       (eng_cmd_pop),
        .wr_empty_i      (wr_empty),
        .wr_data_i       (eng_wr_data),
        .wr_mask_i       (eng_wr_mask),
        .wr_pop_o        (eng_wr_pop),
        .rd_full_i       (rd_full),
        .rd_push_o       (eng_rd_push),
        .rd_data_o       (eng_rd_data)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Released on a falling edge like every other DUT input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- bench/tb_wb_mcb.sv
`timescale 1ns/1ps

module tb_wb_mcb;
    import wb_pkg::*;

    localparam int CLK_PERIOD_NS = 40;
    localparam int RST_CYCLES = 8;
    localparam int ACK_LIMIT = 50;
    localparam int IDLE_CYCLES = 10;
    localparam int MEM_ADR_W = 10;
    localparam int MEM_BYTES = 2 ** MEM_ADR_W;
    localparam int N_SINGLE = 8;
    localparam int N_BURST = 16;
    localparam int N_RANDOM = 400;
    // Tests 2 and 4 read back every write, test 3 is four writes and four reads
    localparam int TOTAL_OPS = 2 * N_SINGLE + 8 + 2 * N_BURST + N_RANDOM;
    localparam int WATCHDOG_NS =
        (TOTAL_OPS * ACK_LIMIT + RST_CYCLES + IDLE_CYCLES) * CLK_PERIOD_NS;
    localparam logic [31:0] SEED = 32'h4b27b34e;

    logic     clk;
    logic     rst;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_data_t wb_dat_o;
    logic     wb_we_i;
    logic     wb_stb_i;
    logic     wb_cyc_i;
    logic     wb_ack_o;

    // Shadow memory, one byte per bus address
    wb_data_t shadow [MEM_BYTES];
    int       written_q[$];

    // Expectation for the one access on the bus, stable until the next issue
    logic     exp_rd;
    wb_data_t exp_dat;
    string    exp_name;
    int       issued = 0;
    int       reads_issued = 0;
    int       ack_errors = 0;

    // Owned by the compare process
    int       acks_seen = 0;
    int       reads_checked = 0;
    int       data_errors = 0;
    int       stray_acks = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    wb_mcb_top #(.MEM_ADDR_W(8), .FIFO_DEPTH(4)) dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (wb_stb_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_ack_o (wb_ack_o)
    );

    function automatic wb_data_t ref_read_byte(input wb_addr_t adr);
        return shadow[adr[MEM_ADR_W-1:0]];
    endfunction

    task automatic check_byte(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            data_errors++;
            $display("[FAIL] %s expected 0x%02h actual 0x%02h", name, exp, act);
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            ack_errors++;
            if (exp) begin
                $display("%s received no ack within %0d cycles", name, ACK_LIMIT);
            end else begin
                $display("[FAIL] %s expected ack %0b actual %0b", name, exp, act);
            end
        end
    endtask

    task automatic bus_access(input string name, input logic we, input wb_addr_t adr,
                              input wb_data_t dat);
        int   cycles;
        logic acked;
        cycles = 0;
        acked = 1'b0;
        @(negedge clk);
        exp_rd = ~we;
        exp_dat = we ? dat : ref_read_byte(adr);
        exp_name = name;
        issued++;
        if (!we) begin
            reads_issued++;
        end
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_we_i = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        while (!acked && cycles < ACK_LIMIT) begin
            @(negedge clk);
            cycles++;
            acked = (wb_ack_o === 1'b1);
        end
        // Strobe stays low through at least one rising edge
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        check_ack(name, 1'b1, acked);
        if (acked && we) begin
            shadow[adr[MEM_ADR_W-1:0]] = dat;
            written_q.push_back(int'(adr[MEM_ADR_W-1:0]));
        end
    endtask

    task automatic bus_write(input string name, input wb_addr_t adr, input wb_data_t dat);
        bus_access(name, 1'b1, adr, dat);
    endtask

    task automatic bus_read(input string name, input wb_addr_t adr);
        bus_access(name, 1'b0, adr, '0);
    endtask

    always @(negedge clk) begin
        if (!rst && wb_ack_o === 1'b1) begin
            if (acks_seen >= issued) begin
                stray_acks++;
                $display("Ack at %0t ns came with no bus access in progress", $time);
            end else begin
                acks_seen++;
                if (exp_rd) begin
                    check_byte(exp_name, exp_dat, wb_dat_o);
                    reads_checked++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        wb_addr_t adr;
        wb_addr_t base;
        wb_addr_t burst_adr [N_BURST];
        wb_data_t lane_val [4];
        wb_data_t dat;
        int       idx;

        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        void'($urandom(SEED));
        @(negedge rst);

        // Quiet bus after reset
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_ack("idle_after_reset", 1'b0, wb_ack_o);
        end

        for (int i = 0; i < N_SINGLE; i++) begin
            adr = wb_addr_t'($urandom % MEM_BYTES);
            dat = wb_data_t'($urandom);
            bus_write($sformatf("single_wr_%0d", i), adr, dat);
            bus_read($sformatf("single_rd_%0d", i), adr);
        end

        // All four lanes of one word, distinct values
        base = wb_addr_t'(($urandom % (MEM_BYTES / 4)) * 4);
        dat = wb_data_t'($urandom);
        for (int k = 0; k < 4; k++) begin
            lane_val[k] = dat + wb_data_t'(8'h35 * k);
            bus_write($sformatf("lane_wr_%0d", k), base + wb_addr_t'(k), lane_val[k]);
        end
        for (int k = 0; k < 4; k++) begin
            bus_read($sformatf("lane_rd_%0d", k), base + wb_addr_t'(k));
        end

        // Writes with only the one idle strobe cycle the bus requires
        for (int i = 0; i < N_BURST; i++) begin
            burst_adr[i] = wb_addr_t'($urandom % MEM_BYTES);
            bus_write($sformatf("burst_wr_%0d", i), burst_adr[i], wb_data_t'($urandom));
        end
        for (int i = 0; i < N_BURST; i++) begin
            bus_read($sformatf("burst_rd_%0d", i), burst_adr[i]);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            if (written_q.size() == 0 || ($urandom % 2) == 0) begin
                adr = wb_addr_t'($urandom % MEM_BYTES);
                bus_write($sformatf("rand_wr_%0d", i), adr, wb_data_t'($urandom));
            end else begin
                idx = int'($urandom % written_q.size());
                bus_read($sformatf("rand_rd_%0d", i), wb_addr_t'(written_q[idx]));
            end
        end

        repeat (4) @(negedge clk);
        if (reads_checked != reads_issued) begin
            $display("Only %0d of %0d reads returned data", reads_checked, reads_issued);
        end
        $display("Summary: %0d reads compared, %0d data errors, %0d ack errors, %0d stray acks",
                 reads_checked, data_errors, ack_errors, stray_acks);
        if (data_errors == 0 && ack_errors == 0 && stray_acks == 0
            && reads_checked == reads_issued) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
common/wb_pkg.sv
common/mcb_pkg.sv
hw/wb_mcb_8.sv
mcb_model/mcb_fifo.sv
mcb_model/mcb_mem_engine.sv
hw/wb_mcb_top.sv
bench/tb_clk_gen.sv
bench/tb_wb_mcb.sv

//--- Makefile
# Verilator build and run for the Wishbone to memory port bridge

VERILATOR ?= verilator
TOP       ?= tb_wb_mcb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= >>> PASS

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
